// ==== build.f ====
+incdir+hdl
hdl/host_chan_pkg.sv
hdl/tx_stream_map.sv
hdl/rx_stream_map.sv
hdl/host_chan_map.sv
test/tb_host_chan.sv

// ==== hdl/host_chan_defines.svh ====
`ifndef HOST_CHAN_DEFINES_SVH
`define HOST_CHAN_DEFINES_SVH

// Width of one stream beat in bits, shared by both stream formats
`define HC_TDATA_WIDTH 512

// Number of PCIe subsystem segments carried in one beat
`define HC_NUM_SEG 2

// Width of the subsystem vendor user field
`define HC_TUSER_VENDOR_WIDTH 10

// Vendor user bit that asks the subsystem for a local commit of a store.
// Bit 0 is already taken by the PU/DM format flag
`define HC_STORE_COMMIT_BIT 1

// Low bit of the 8-bit TLP fmt_type field inside the header dword.
// The header sits at the bottom of the data word
`define HC_FMT_TYPE_LSB 24

`endif

// ==== hdl/host_chan_map.sv ====
`timescale 1ns/1ps

// Host-channel gasket between the PCIe subsystem and the platform streams.
// TX B carries reads, TX A carries writes, interrupts and everything else.
// RX A carries host traffic, RX B carries locally generated write completions
module host_chan_map
    import host_chan_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,

    // Transmit streams, accelerator to host
    input  pim_beat_t pim_tx_a_beat,
    input  logic      pim_tx_a_valid,
    output logic      pim_tx_a_ready,
    input  pim_beat_t pim_tx_b_beat,
    input  logic      pim_tx_b_valid,
    output logic      pim_tx_b_ready,

    output ss_beat_t  ss_tx_a_beat,
    output logic      ss_tx_a_valid,
    input  logic      ss_tx_a_ready,
    output ss_beat_t  ss_tx_b_beat,
    output logic      ss_tx_b_valid,
    input  logic      ss_tx_b_ready,

    // Receive streams, host to accelerator
    input  ss_beat_t  ss_rx_a_beat,
    input  logic      ss_rx_a_valid,
    output logic      ss_rx_a_ready,
    input  ss_beat_t  ss_rx_b_beat,
    input  logic      ss_rx_b_valid,
    output logic      ss_rx_b_ready,

    output pim_beat_t pim_rx_a_beat,
    output logic      pim_rx_a_valid,
    input  logic      pim_rx_a_ready,
    output pim_beat_t pim_rx_b_beat,
    output logic      pim_rx_b_valid,
    input  logic      pim_rx_b_ready
);

    // Stores and interrupts leave on TX A, so only A asks for commits
    tx_stream_map #(
        .COMMIT_REQ_ENABLE (1)
    ) u_tx_a (
        .pim_beat  (pim_tx_a_beat),
        .pim_valid (pim_tx_a_valid),
        .pim_ready (pim_tx_a_ready),
        .ss_beat   (ss_tx_a_beat),
        .ss_valid  (ss_tx_a_valid),
        .ss_ready  (ss_tx_a_ready)
    );

    // Reads never need a commit
    tx_stream_map #(
        .COMMIT_REQ_ENABLE (0)
    ) u_tx_b (
        .pim_beat  (pim_tx_b_beat),
        .pim_valid (pim_tx_b_valid),
        .pim_ready (pim_tx_b_ready),
        .ss_beat   (ss_tx_b_beat),
        .ss_valid  (ss_tx_b_valid),
        .ss_ready  (ss_tx_b_ready)
    );

    // Each receive stream tracks its own packet boundaries
    rx_stream_map u_rx_a (
        .clk       (clk),
        .reset_n   (reset_n),
        .ss_beat   (ss_rx_a_beat),
        .ss_valid  (ss_rx_a_valid),
        .ss_ready  (ss_rx_a_ready),
        .pim_beat  (pim_rx_a_beat),
        .pim_valid (pim_rx_a_valid),
        .pim_ready (pim_rx_a_ready)
    );

    rx_stream_map u_rx_b (
        .clk       (clk),
        .reset_n   (reset_n),
        .ss_beat   (ss_rx_b_beat),
        .ss_valid  (ss_rx_b_valid),
        .ss_ready  (ss_rx_b_ready),
        .pim_beat  (pim_rx_b_beat),
        .pim_valid (pim_rx_b_valid),
        .pim_ready (pim_rx_b_ready)
    );

endmodule

// ==== hdl/host_chan_pkg.sv ====
`include "host_chan_defines.svh"

package host_chan_pkg;

    // One data word of a beat
    typedef logic [`HC_TDATA_WIDTH-1:0] tdata_t;

    // Byte keep bits, one per data byte
    typedef logic [`HC_TDATA_WIDTH/8-1:0] tkeep_t;

    // Vendor user field on the subsystem side
    typedef logic [`HC_TUSER_VENDOR_WIDTH-1:0] vendor_t;

    // TLP fmt_type byte as found in the header
    typedef logic [7:0] fmt_type_t;

    // Per-segment user bits of the platform stream.
    // dm_mode selects DM (1) or PU (0) header format
    typedef struct packed {
        logic dm_mode;
        logic sop;
        logic eop;
    } seg_user_t;

    // Platform user field, one entry per subsystem segment
    typedef seg_user_t [`HC_NUM_SEG-1:0] pim_user_t;

    // Payload of the platform stream
    typedef struct packed {
        tdata_t    data;
        tkeep_t    keep;
        logic      last;
        pim_user_t user;
    } pim_beat_t;

    // Payload of the PCIe subsystem stream.
    // On transmit the keep bits are only meaningful at dword granularity
    typedef struct packed {
        tdata_t  tdata;
        tkeep_t  tkeep;
        logic    tlast;
        vendor_t tuser_vendor;
    } ss_beat_t;

    // Memory write, 32-bit address
    localparam fmt_type_t FMT_MWR32 = 8'h40;

    // Memory write, 64-bit address
    localparam fmt_type_t FMT_MWR64 = 8'h60;

    // Interrupt request
    localparam fmt_type_t FMT_INTR = 8'h30;

endpackage

// ==== hdl/rx_stream_map.sv ====
`timescale 1ns/1ps

`include "host_chan_defines.svh"

// Converts one PCIe subsystem receive stream into the platform format.
// The payload path is combinational; the only state is the SOP flag
module rx_stream_map
    import host_chan_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,

    input  ss_beat_t  ss_beat,
    input  logic      ss_valid,
    output logic      ss_ready,

    output pim_beat_t pim_beat,
    output logic      pim_valid,
    input  logic      pim_ready
);

    // Bytes per subsystem segment, used to find the first keep bit of each
    localparam int SEG_BYTES = `HC_TDATA_WIDTH / `HC_NUM_SEG / 8;

    // High when the next beat on the stream starts a packet
    logic is_sop;

    // High when at least one segment of the beat holds payload
    logic any_seg_valid;

    // Handshake passes straight through in both directions
    assign pim_valid = ss_valid;
    assign ss_ready  = pim_ready;

    // A segment holds payload when its first byte is kept
    always_comb
    begin
        any_seg_valid = 1'b0;
        for (int s = 0; s < `HC_NUM_SEG; s++)
        begin
            any_seg_valid = any_seg_valid | ss_beat.tkeep[s * SEG_BYTES];
        end
    end

    always_comb
    begin
        pim_beat.data = ss_beat.tdata;
        pim_beat.keep = ss_beat.tkeep;
        pim_beat.last = ss_beat.tlast;

        // Segment 1 user bits stay clear since headers only start in segment 0
        pim_beat.user = '0;
        pim_beat.user[0].dm_mode = ss_beat.tuser_vendor[0];
        pim_beat.user[0].sop     = is_sop;

        // At most one EOP is marked, and only on a beat that carries data
        pim_beat.user[0].eop = any_seg_valid & ss_beat.tlast;
    end

    // The packet after an accepted last beat is a new SOP.
    // A stalled beat leaves the flag alone until it is taken
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            is_sop <= 1'b1;
        end
        else if (ss_valid && ss_ready)
        begin
            is_sop <= ss_beat.tlast;
        end
    end

endmodule

// ==== hdl/tx_stream_map.sv ====
`timescale 1ns/1ps

`include "host_chan_defines.svh"

// Converts one platform transmit stream into the PCIe subsystem format.
// The whole path is combinational and adds no latency
module tx_stream_map
    import host_chan_pkg::*;
#(
    // Set to 1 to flag memory writes and interrupts for a local commit
    parameter int COMMIT_REQ_ENABLE = 0
)
(
    input  pim_beat_t pim_beat,
    input  logic      pim_valid,
    output logic      pim_ready,

    output ss_beat_t  ss_beat,
    output logic      ss_valid,
    input  logic      ss_ready
);

    // Number of dwords in one beat
    localparam int NUM_DWORDS = `HC_TDATA_WIDTH / 32;

    fmt_type_t hdr_fmt_type;
    logic      is_commit_type;

    // Handshake passes straight through in both directions
    assign ss_valid  = pim_valid;
    assign pim_ready = ss_ready;

    // The header occupies the low bits of the data word on an SOP beat
    assign hdr_fmt_type = pim_beat.data[`HC_FMT_TYPE_LSB +: 8];

    // Stores and interrupts are the TLPs that want a commit from the subsystem
    assign is_commit_type = (hdr_fmt_type == FMT_MWR32) ||
                            (hdr_fmt_type == FMT_MWR64) ||
                            (hdr_fmt_type == FMT_INTR);

    always_comb
    begin
        ss_beat.tdata = pim_beat.data;
        ss_beat.tlast = pim_beat.last;

        // Masks are dword granular, so the first keep bit of each dword
        // stands for the whole dword
        for (int w = 0; w < NUM_DWORDS; w++)
        begin
            ss_beat.tkeep[w*4 +: 4] = {4{pim_beat.keep[w*4]}};
        end

        // Only segment 0 carries a header, so its format flag is the one used
        ss_beat.tuser_vendor    = '0;
        ss_beat.tuser_vendor[0] = pim_beat.user[0].dm_mode;

        // The commit request belongs to the header beat only; payload beats
        // of a long write must never set it
        ss_beat.tuser_vendor[`HC_STORE_COMMIT_BIT] = (COMMIT_REQ_ENABLE != 0) &&
                                                     pim_beat.user[0].sop &&
                                                     is_commit_type;
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_host_chan \
    -f build.f -o tb_host_chan

sim_output=$(./obj_dir/tb_host_chan)
echo "$sim_output"

if echo "$sim_output" | grep -qx "Regression passed"; then
    exit 0
else
    exit 1
fi

// ==== test/host_chan_input.txt ====
# stream valid ready last keep seed dm_mode sop fmt_type exp_keep exp_tuser_vendor exp_user
# All hex; exp_user packs {seg1, seg0} with each segment as {dm_mode, sop, eop}
txa 1 1 0 ffffffffffffffff 000001 0 1 40 ffffffffffffffff 002 00
txa 1 1 1 000000000000ffff 000002 1 0 40 000000000000ffff 001 00
txa 1 1 1 0000000000001111 000003 1 1 60 000000000000ffff 003 00
txa 1 1 1 5a5a5a5a5a5a5a5a 000004 0 1 30 f0f0f0f0f0f0f0f0 002 00
txa 1 1 1 ffffffffffffffff 000005 0 1 00 ffffffffffffffff 000 00
txa 1 1 1 00000000ffffffff 000006 1 1 20 00000000ffffffff 001 00
txa 1 1 0 ffffffffffffffff 000007 0 1 4a ffffffffffffffff 000 00
txa 1 0 0 ffffffffffffffff 000008 0 1 60 ffffffffffffffff 002 00
txa 1 1 0 ffffffffffffffff 000008 0 1 60 ffffffffffffffff 002 00
txa 0 1 0 0000000000000000 000000 0 0 00 0000000000000000 000 00
txa 1 1 1 3333333333333333 000009 1 0 30 ffffffffffffffff 001 00
txa 0 0 0 2222222222222222 00000a 0 1 40 0000000000000000 002 00
txb 1 1 1 ffffffffffffffff 000011 0 1 00 ffffffffffffffff 000 00
txb 1 1 1 ffffffffffffffff 000012 1 1 40 ffffffffffffffff 001 00
txb 1 1 1 ffffffffffffffff 000013 0 1 60 ffffffffffffffff 000 00
txb 1 1 1 ffffffffffffffff 000014 1 1 30 ffffffffffffffff 001 00
txb 1 0 0 0123456789abcdef 000015 0 1 20 0f0f0f0f0f0f0f0f 000 00
txb 0 1 0 0000000000000000 000000 0 0 00 0000000000000000 000 00
rxa 1 1 0 ffffffffffffffff 000021 0 0 00 ffffffffffffffff 000 02
rxa 1 0 1 ffffffffffffffff 000022 1 0 00 ffffffffffffffff 000 05
rxa 1 0 1 ffffffffffffffff 000022 1 0 00 ffffffffffffffff 000 05
rxa 1 1 1 ffffffffffffffff 000022 1 0 00 ffffffffffffffff 000 05
rxa 1 1 1 00000000ffffffff 000023 0 0 00 00000000ffffffff 000 03
rxa 1 1 1 ffffffff00000000 000024 0 0 00 ffffffff00000000 000 03
rxa 1 1 1 fffffffefffffffe 000025 1 0 00 fffffffefffffffe 000 06
rxa 1 1 0 ffffffffffffffff 000026 0 0 00 ffffffffffffffff 000 02
rxa 0 1 1 ffffffffffffffff 000027 0 0 00 ffffffffffffffff 000 01
rxa 1 1 0 ffffffffffffffff 000028 1 0 00 ffffffffffffffff 000 04
rxa 1 1 1 000000000000000f 000029 0 0 00 000000000000000f 000 01
rxb 1 1 0 ffffffffffffffff 000031 0 0 00 ffffffffffffffff 000 02
rxa 1 1 0 ffffffffffffffff 00002a 0 0 00 ffffffffffffffff 000 02
rxb 1 0 1 ffffffffffffffff 000032 1 0 00 ffffffffffffffff 000 05
rxb 1 1 1 ffffffffffffffff 000032 1 0 00 ffffffffffffffff 000 05
rxa 1 1 1 ffffffffffffffff 00002b 0 0 00 ffffffffffffffff 000 01
rxb 1 1 1 0000000100000000 000033 0 0 00 0000000100000000 000 03
rxb 1 1 1 0000000000000000 000034 1 0 00 0000000000000000 000 06
rxb 0 0 0 0000000000000000 000000 0 0 00 0000000000000000 000 02
rxa 0 0 0 0000000000000000 000000 0 0 00 0000000000000000 000 02

// ==== test/tb_host_chan.sv ====
`timescale 1ns/1ps

`include "host_chan_defines.svh"

// Self-checking testbench for the host-channel gasket.
// Each line of the data file drives one stream for one clock cycle
module tb_host_chan
    import host_chan_pkg::*;
();

    localparam int SEG_BYTES     = `HC_TDATA_WIDTH / `HC_NUM_SEG / 8;
    localparam int RESET_TIMEOUT = 64;
    localparam int MAX_LINES     = 1000;

    logic      clk;
    logic      reset_n;
    pim_beat_t pim_tx_a_beat, pim_tx_b_beat, pim_rx_a_beat, pim_rx_b_beat;
    ss_beat_t  ss_tx_a_beat, ss_tx_b_beat, ss_rx_a_beat, ss_rx_b_beat;
    logic      pim_tx_a_valid, pim_tx_a_ready, pim_tx_b_valid, pim_tx_b_ready;
    logic      ss_tx_a_valid, ss_tx_a_ready, ss_tx_b_valid, ss_tx_b_ready;
    logic      ss_rx_a_valid, ss_rx_a_ready, ss_rx_b_valid, ss_rx_b_ready;
    logic      pim_rx_a_valid, pim_rx_a_ready, pim_rx_b_valid, pim_rx_b_ready;

    // Fields of the current data file line
    logic [31:0] vec_stream;
    logic        vec_valid, vec_ready, vec_last, vec_dm, vec_sop;
    tkeep_t      vec_keep, file_keep;
    logic [31:0] vec_seed, file_vendor, file_user;
    fmt_type_t   vec_fmt;
    tdata_t      vec_data;

    // Reference SOP flags, one per receive stream
    logic model_sop_a, model_sop_b;
    int   value_errors = 0;
    int   other_errors = 0;
    int   line_no      = 0;

    host_chan_map i_dut (.*);

    always #5 clk = ~clk;

    initial
    begin
        reset_n = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
    end

    // Every dword keep bit 4w covers bytes 4w to 4w+3
    function automatic tkeep_t widen_keep(input tkeep_t dword_keep);
        tkeep_t byte_keep;
        for (int b = 0; b < `HC_TDATA_WIDTH / 8; b++)
        begin
            byte_keep[b] = dword_keep[b - (b % 4)];
        end
        return byte_keep;
    endfunction

    // Commit is asked only for stores and interrupts at the start of a packet
    function automatic vendor_t tx_vendor_bits(input logic dm, input logic sop,
                                               input fmt_type_t fmt, input logic commit_en);
        vendor_t vendor;
        logic    store_or_intr;
        store_or_intr = (fmt == FMT_MWR32) || (fmt == FMT_MWR64) || (fmt == FMT_INTR);
        vendor        = '0;
        vendor[0]     = dm;
        vendor[`HC_STORE_COMMIT_BIT] = commit_en && sop && store_or_intr;
        return vendor;
    endfunction

    // EOP shows only when some segment keeps its first byte
    function automatic pim_user_t rx_user_bits(input logic dm, input logic sop,
                                               input logic last, input tkeep_t keep);
        pim_user_t user;
        logic      has_payload;
        has_payload = 1'b0;
        for (int s = 0; s < `HC_NUM_SEG; s++)
        begin
            has_payload = has_payload | keep[s * SEG_BYTES];
        end
        user            = '0;
        user[0].dm_mode = dm;
        user[0].sop     = sop;
        user[0].eop     = last && has_payload;
        return user;
    endfunction

    task automatic compare_value(input string name, input tdata_t expected,
                                 input tdata_t actual);
        assert (actual === expected)
        else
        begin
            $display("ERROR at %0d ns: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
            value_errors++;
        end
    endtask

    // The file's expected columns must agree with the mapping rules
    task automatic audit_file_column(input string column, input logic [63:0] in_file,
                                     input logic [63:0] by_rule);
        assert (in_file === by_rule)
        else
        begin
            $display("Data file line %0d: the expected %s column disagrees with the rules",
                     line_no, column);
            other_errors++;
        end
    endtask

    task automatic clear_inputs();
        pim_tx_a_beat  = '0;
        pim_tx_b_beat  = '0;
        ss_rx_a_beat   = '0;
        ss_rx_b_beat   = '0;
        pim_tx_a_valid = 1'b0;
        pim_tx_b_valid = 1'b0;
        ss_rx_a_valid  = 1'b0;
        ss_rx_b_valid  = 1'b0;
        ss_tx_a_ready  = 1'b0;
        ss_tx_b_ready  = 1'b0;
        pim_rx_a_ready = 1'b0;
        pim_rx_b_ready = 1'b0;
    endtask

    task automatic wait_reset_release(output logic released);
        int cycles;
        released = 1'b0;
        cycles   = 0;
        while (!released && cycles < RESET_TIMEOUT)
        begin
            @(negedge clk);
            released = reset_n;
            cycles++;
        end
    endtask

    task automatic drive_vector();
        pim_beat_t tx_beat;
        ss_beat_t  rx_beat;
        // Payload past the header dword is random filler
        for (int i = 1; i < `HC_TDATA_WIDTH / 32; i++)
        begin
            vec_data[i*32 +: 32] = $urandom;
        end
        vec_data[31:0] = vec_seed;
        vec_data[`HC_FMT_TYPE_LSB +: 8] = vec_fmt;
        tx_beat                 = '0;
        tx_beat.data            = vec_data;
        tx_beat.keep            = vec_keep;
        tx_beat.last            = vec_last;
        tx_beat.user[0].dm_mode = vec_dm;
        tx_beat.user[0].sop     = vec_sop;
        rx_beat                 = '0;
        rx_beat.tdata           = vec_data;
        rx_beat.tkeep           = vec_keep;
        rx_beat.tlast           = vec_last;
        rx_beat.tuser_vendor[0] = vec_dm;
        // Streams not named on the line stay idle
        clear_inputs();
        case (vec_stream)
            "txa":
            begin
                pim_tx_a_beat  = tx_beat;
                pim_tx_a_valid = vec_valid;
                ss_tx_a_ready  = vec_ready;
            end
            "txb":
            begin
                pim_tx_b_beat  = tx_beat;
                pim_tx_b_valid = vec_valid;
                ss_tx_b_ready  = vec_ready;
            end
            "rxa":
            begin
                ss_rx_a_beat   = rx_beat;
                ss_rx_a_valid  = vec_valid;
                pim_rx_a_ready = vec_ready;
            end
            "rxb":
            begin
                ss_rx_b_beat   = rx_beat;
                ss_rx_b_valid  = vec_valid;
                pim_rx_b_ready = vec_ready;
            end
            default:
            begin
                $display("Data file line %0d names an unknown stream", line_no);
                other_errors++;
            end
        endcase
    endtask

    task automatic verify_tx_outputs(input string side, input ss_beat_t beat,
                                     input logic valid, input logic ready,
                                     input logic commit_en);
        tkeep_t  rule_keep;
        vendor_t rule_vendor;
        rule_keep   = widen_keep(vec_keep);
        rule_vendor = tx_vendor_bits(vec_dm, vec_sop, vec_fmt, commit_en);
        audit_file_column("keep", file_keep, rule_keep);
        audit_file_column("vendor", file_vendor, rule_vendor);
        audit_file_column("user", file_user, '0);
        compare_value({"ss_tx_", side, "_beat.tdata"}, vec_data, beat.tdata);
        compare_value({"ss_tx_", side, "_beat.tlast"}, vec_last, beat.tlast);
        compare_value({"ss_tx_", side, "_beat.tkeep"}, rule_keep, beat.tkeep);
        compare_value({"ss_tx_", side, "_beat.tuser_vendor"}, rule_vendor, beat.tuser_vendor);
        compare_value({"ss_tx_", side, "_valid"}, vec_valid, valid);
        compare_value({"pim_tx_", side, "_ready"}, vec_ready, ready);
    endtask

    task automatic verify_rx_outputs(input string side, input pim_beat_t beat,
                                     input logic valid, input logic ready,
                                     input logic sop_now);
        pim_user_t rule_user;
        rule_user = rx_user_bits(vec_dm, sop_now, vec_last, vec_keep);
        audit_file_column("keep", file_keep, vec_keep);
        audit_file_column("vendor", file_vendor, '0);
        audit_file_column("user", file_user, rule_user);
        compare_value({"pim_rx_", side, "_beat.data"}, vec_data, beat.data);
        compare_value({"pim_rx_", side, "_beat.keep"}, vec_keep, beat.keep);
        compare_value({"pim_rx_", side, "_beat.last"}, vec_last, beat.last);
        compare_value({"pim_rx_", side, "_beat.user"}, rule_user, beat.user);
        compare_value({"pim_rx_", side, "_valid"}, vec_valid, valid);
        compare_value({"ss_rx_", side, "_ready"}, vec_ready, ready);
    endtask

    // Checks the driven stream, then advances the SOP model on an accepted beat
    task automatic score_vector();
        case (vec_stream)
            "txa": verify_tx_outputs("a", ss_tx_a_beat, ss_tx_a_valid, pim_tx_a_ready, 1'b1);
            "txb": verify_tx_outputs("b", ss_tx_b_beat, ss_tx_b_valid, pim_tx_b_ready, 1'b0);
            "rxa":
            begin
                verify_rx_outputs("a", pim_rx_a_beat, pim_rx_a_valid, ss_rx_a_ready, model_sop_a);
                if (vec_valid && vec_ready)
                begin
                    model_sop_a = vec_last;
                end
            end
            "rxb":
            begin
                verify_rx_outputs("b", pim_rx_b_beat, pim_rx_b_valid, ss_rx_b_ready, model_sop_b);
                if (vec_valid && vec_ready)
                begin
                    model_sop_b = vec_last;
                end
            end
            default:
            begin
            end
        endcase
    endtask

    initial
    begin
        int    fd;
        int    fields;
        string line;
        logic  released;

        clk = 1'b0;
        clear_inputs();
        void'($urandom(75));
        model_sop_a = 1'b1;
        model_sop_b = 1'b1;
        wait_reset_release(released);
        fd = $fopen("test/host_chan_input.txt", "r");
        if (!released)
        begin
            $display("Timed out waiting for reset to be released");
            other_errors++;
        end
        else if (fd == 0)
        begin
            $display("Could not open the stimulus file test/host_chan_input.txt");
            other_errors++;
        end
        else
        begin
            // With every input low after reset, no stream may show a valid beat
            compare_value("ss_tx_a_valid", '0, ss_tx_a_valid);
            compare_value("ss_tx_b_valid", '0, ss_tx_b_valid);
            compare_value("pim_rx_a_valid", '0, pim_rx_a_valid);
            compare_value("pim_rx_b_valid", '0, pim_rx_b_valid);
            while (!$feof(fd) && line_no < MAX_LINES)
            begin
                line_no++;
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 2 && line[0] != "#")
                begin
                    fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h",
                                     vec_stream, vec_valid, vec_ready, vec_last, vec_keep,
                                     vec_seed, vec_dm, vec_sop, vec_fmt, file_keep,
                                     file_vendor, file_user);
                    if (fields != 12)
                    begin
                        $display("Data file line %0d is malformed", line_no);
                        other_errors++;
                    end
                    else
                    begin
                        // Drive on the falling edge, sample just before the rising one
                        @(negedge clk);
                        drive_vector();
                        #4;
                        score_vector();
                    end
                end
            end
            $fclose(fd);
        end
        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
